//--- prom_pkg.sv
// --------------------------------------------------
// 25AA128 SPI EEPROM programmer shared definitions
// opcodes, sequencer states, host addresses and
// the bit layout of the status word
// --------------------------------------------------
package prom_pkg;

    // 25AA128 instruction set
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,               // no operation
        OP_WRSR  = 8'h01,               // write status reg
        OP_WRITE = 8'h02,               // page write, block window only
        OP_READ  = 8'h03,               // page read
        OP_WRDI  = 8'h04,               // clear write enable latch
        OP_RDSR  = 8'h05,               // read status reg
        OP_WREN  = 8'h06                // set write enable latch
    } prom_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SELECT,
        ST_SEND,
        ST_SEND_BLOCK,
        ST_RECV,
        ST_DESELECT
    } prom_state_t;

    // --------------------------------------------------
    // host address map
    // --------------------------------------------------
    localparam logic [15:0] REG_CMD_ADDR = 16'h000a;   // command register
    localparam logic [3:0]  BLK_REGION   = 4'h2;       // top nibble of block window

    // page geometry, 64 bytes
    localparam int PAGE_QUADS = 16;
    localparam int QIDX_W     = 5;                     // index counts up to 16 and past

    // half-cycle counter, 2*bits-1
    localparam int          NHALF_W    = 6;
    localparam logic [5:0]  WORD_NHALF = 6'd63;        // one full quadlet

    // --------------------------------------------------
    // prom_status layout
    // --------------------------------------------------
    localparam int STAT_DEBUG_LSB = 16;                // 31:16 debug word
    localparam int STAT_CS        = 7;
    localparam int STAT_SCLK      = 6;
    localparam int STAT_MISO      = 5;
    localparam int STAT_MOSI      = 4;
    localparam int STAT_BLK_WRT   = 3;
    localparam int STAT_STATE_MSB = 2;                 // 2:0 sequencer state

endpackage

//--- prom_block_buffer.sv
// --------------------------------------------------
// page buffer for the EEPROM programmer
// takes host block writes in index order, logs
// address errors, stores READ data and serves
// registered host readback
// --------------------------------------------------
`timescale 1ns/10ps

module prom_block_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [15:0]                   reg_waddr,
    input  logic [15:0]                   reg_raddr,
    input  logic                          reg_wen,
    input  logic                          blk_wstart,
    input  logic                          blk_wen,
    input  logic [31:0]                   prom_cmd,
    input  logic                          seq_idle,
    input  logic                          clr_index,
    input  logic                          cap_wen,
    input  logic [31:0]                   cap_data,
    input  logic [prom_pkg::QIDX_W-1:0]   rd_index,
    output logic                          blk_wrt,
    output logic [prom_pkg::QIDX_W-1:0]   wr_index,
    output logic [31:0]                   buf_rdata,
    output logic [31:0]                   prom_rdata,
    output logic [15:0]                   debug_word
);
    import prom_pkg::*;

    logic [31:0] mem [PAGE_QUADS];         // page storage
    logic        blk_win;                  // write address in block window
    logic        blk_acc;                  // in-order quadlet
    logic        blk_bad;                  // out-of-order quadlet

    assign blk_win = (reg_waddr[15:12] == BLK_REGION);
    assign blk_acc = blk_win && reg_wen && blk_wrt && (reg_waddr[3:0] == wr_index[3:0]);
    assign blk_bad = blk_win && reg_wen && blk_wrt && (reg_waddr[3:0] != wr_index[3:0]);

    assign buf_rdata = mem[rd_index[3:0]];  // sequencer side, no latency

    // --------------------------------------------------
    // block flag, write index and error log
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset) begin
            blk_wrt    <= 1'b0;
            wr_index   <= '0;
            debug_word <= '0;
        end else if (clr_index) begin                   // new command
            blk_wrt  <= 1'b0;
            wr_index <= '0;
        end else if (blk_win && blk_wstart && seq_idle && !blk_wrt) begin
            blk_wrt    <= 1'b1;
            wr_index   <= '0;
            debug_word <= '0;                            // fresh error log
        end else if (blk_acc) begin
            wr_index <= wr_index + 1'b1;
        end else if (blk_bad) begin
            // bad nibble, then the index we wanted
            debug_word <= {4'h0, reg_waddr[3:0], 3'h0, wr_index};
        end else if (blk_win && blk_wen) begin
            blk_wrt <= 1'b0;                             // host done, stream may go on
        end else if (cap_wen) begin
            wr_index <= wr_index + 1'b1;                 // READ fill
        end
    end

    // storage and host readback
    always_ff @(posedge clk) begin
        if (blk_acc)
            mem[wr_index[3:0]] <= prom_cmd;              // wraps for the 17th quadlet
        else if (cap_wen)
            mem[wr_index[3:0]] <= cap_data;
        prom_rdata <= (reg_raddr[15:12] == BLK_REGION) ? mem[reg_raddr[3:0]] : 32'd0;
    end

endmodule

//--- prom_spi_shifter.sv
// --------------------------------------------------
// SPI bit engine, mode 0
// half-cycle counter makes sclk, shifts one word
// out MSB first or samples miso into rx_word
// --------------------------------------------------
`timescale 1ns/10ps

module prom_spi_shifter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          shift_start,
    input  logic [31:0]                   tx_word,
    input  logic [prom_pkg::NHALF_W-1:0]  n_half,
    input  logic                          rx_mode,
    input  logic                          prom_miso,
    output logic                          prom_sclk,
    output logic                          prom_mosi,
    output logic [31:0]                   rx_word,
    output logic                          word_done
);
    import prom_pkg::*;

    logic               active;            // word in flight
    logic [NHALF_W-1:0] cnt;               // half-cycle count
    logic [NHALF_W-1:0] n_half_q;          // terminal count
    logic [31:0]        shreg;             // tx shift reg

    assign prom_sclk = cnt[0];             // odd count = sclk high
    assign prom_mosi = shreg[31];
    assign word_done = active && (cnt == n_half_q);

    // --------------------------------------------------
    // counter and tx shift
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset) begin
            active <= 1'b0;
            cnt    <= '0;
            shreg  <= '0;                  // mosi low out of reset
        end else if (shift_start) begin    // also back to back on word_done
            active <= 1'b1;
            cnt    <= '0;
            shreg  <= tx_word;
        end else if (active) begin
            if (word_done) begin
                active <= 1'b0;
                cnt    <= '0;              // sclk drops
            end else begin
                cnt <= cnt + 1'b1;
            end
            if (cnt[0] && !rx_mode)
                shreg <= {shreg[30:0], 1'b0};   // next bit as sclk falls
        end
    end

    // rx side, sample as sclk goes high
    always_ff @(posedge clk) begin
        if (shift_start) begin
            n_half_q <= n_half;
            rx_word  <= '0;                // short reads come back zero padded
        end else if (active && rx_mode && !cnt[0]) begin
            rx_word <= {rx_word[30:0], prom_miso};
        end
    end

endmodule

//--- prom_sequencer.sv
// --------------------------------------------------
// EEPROM command sequencer
// decodes command writes, picks transfer lengths
// per opcode, walks chip select through the send,
// receive and block stream phases, sets the result
// --------------------------------------------------
`timescale 1ns/10ps

module prom_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [15:0]                   reg_waddr,
    input  logic                          reg_wen,
    input  logic [31:0]                   prom_cmd,
    input  logic                          blk_wrt,
    input  logic [prom_pkg::QIDX_W-1:0]   wr_index,
    input  logic [31:0]                   buf_rdata,
    input  logic [31:0]                   rx_word,
    input  logic                          word_done,
    output logic                          prom_cs,
    output logic                          seq_idle,
    output logic                          clr_index,
    output logic                          cap_wen,
    output logic [31:0]                   cap_data,
    output logic [prom_pkg::QIDX_W-1:0]   rd_index,
    output logic                          shift_start,
    output logic [31:0]                   tx_word,
    output logic [prom_pkg::NHALF_W-1:0]  n_half,
    output logic                          rx_mode,
    output logic [31:0]                   prom_result,
    output prom_pkg::prom_state_t         state
);
    import prom_pkg::*;

    prom_op_t           op;
    logic               cmd_wen;           // write to command reg
    logic [31:0]        cmd_q;             // command quadlet to send
    logic [NHALF_W-1:0] send_n;            // tx half-cycles minus 1
    logic [NHALF_W-1:0] recv_n;            // rx half-cycles minus 1, 0 = none
    logic               page_rd;           // READ, rx goes to buffer
    logic               blk_mode;          // streamed page write
    logic               last_quad;

    assign op        = prom_op_t'(prom_cmd[31:24]);
    assign cmd_wen   = reg_wen && (reg_waddr == REG_CMD_ADDR);
    assign seq_idle  = (state == ST_IDLE);
    assign clr_index = seq_idle && cmd_wen;           // command start
    assign rx_mode   = (state == ST_RECV);
    assign cap_wen   = rx_mode && word_done && page_rd;
    assign cap_data  = rx_word;
    assign last_quad = (wr_index == QIDX_W'(PAGE_QUADS - 1));

    always_ff @(posedge clk) begin
        if (clr_index)
            cmd_q <= prom_cmd;
    end

    // --------------------------------------------------
    // shifter control
    // --------------------------------------------------
    always_comb begin
        shift_start = 1'b0;
        tx_word     = 32'd0;               // rx phases send zeros
        n_half      = recv_n;
        case (state)
            ST_SELECT: begin
                shift_start = 1'b1;
                tx_word     = blk_mode ? buf_rdata : cmd_q;   // quadlet 0 when streaming
                n_half      = blk_mode ? WORD_NHALF : send_n;
            end
            ST_SEND:       shift_start = word_done && (recv_n != '0);
            ST_SEND_BLOCK: begin
                shift_start = word_done && (rd_index != wr_index);
                tx_word     = buf_rdata;
                n_half      = WORD_NHALF;
            end
            ST_RECV:       shift_start = word_done && page_rd && !last_quad;
            default: ;
        endcase
    end

    // --------------------------------------------------
    // phase FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= ST_IDLE;
            prom_cs     <= 1'b1;
            prom_result <= '0;
            send_n      <= '0;
            recv_n      <= '0;
            page_rd     <= 1'b0;
            blk_mode    <= 1'b0;
            rd_index    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_wen) begin
                        blk_mode <= 1'b0;
                        page_rd  <= 1'b0;
                        recv_n   <= '0;
                        case (op)
                            OP_WREN, OP_WRDI: begin
                                send_n <= 6'd15;            // opcode only
                                state  <= ST_SELECT;
                            end
                            OP_RDSR: begin
                                send_n <= 6'd15;
                                recv_n <= 6'd15;            // one status byte
                                state  <= ST_SELECT;
                            end
                            OP_WRSR: begin
                                send_n <= 6'd31;            // opcode + new status
                                state  <= ST_SELECT;
                            end
                            OP_READ: begin
                                send_n  <= 6'd47;           // opcode + 16-bit addr
                                recv_n  <= WORD_NHALF;
                                page_rd <= 1'b1;
                                state   <= ST_SELECT;
                            end
                            OP_NOP, OP_WRITE: ;             // WRITE goes through block window
                            default: ;
                        endcase
                    end else if (blk_wrt && (wr_index != '0)) begin
                        blk_mode <= 1'b1;                   // first quadlet is in
                        rd_index <= '0;
                        state    <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    prom_cs     <= 1'b0;
                    prom_result <= '0;
                    if (blk_mode) begin
                        rd_index <= rd_index + 1'b1;        // quadlet 0 loaded
                        state    <= ST_SEND_BLOCK;
                    end else begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (word_done)
                        state <= (recv_n != '0) ? ST_RECV : ST_DESELECT;
                end
                ST_SEND_BLOCK: begin
                    if (word_done) begin
                        if (rd_index == wr_index) begin     // caught up with host
                            prom_result <= 32'(rd_index);
                            state       <= ST_DESELECT;
                        end else begin
                            rd_index <= rd_index + 1'b1;
                        end
                    end
                end
                ST_RECV: begin
                    if (word_done) begin
                        if (!page_rd) begin
                            prom_result <= rx_word;         // status byte
                            state       <= ST_DESELECT;
                        end else if (last_quad) begin
                            prom_result <= 32'(PAGE_QUADS);
                            state       <= ST_DESELECT;
                        end
                    end
                end
                ST_DESELECT: begin
                    prom_cs <= 1'b1;
                    state   <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- prom_programmer.sv
// --------------------------------------------------
// 25AA128 SPI EEPROM programmer, top level
// page buffer, SPI shifter and command sequencer
// --------------------------------------------------
`timescale 1ns/10ps

module prom_programmer (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] reg_waddr,
    input  logic [15:0] reg_raddr,
    input  logic        reg_wen,
    input  logic        blk_wstart,
    input  logic        blk_wen,
    input  logic [31:0] prom_cmd,
    output logic [31:0] prom_status,
    output logic [31:0] prom_result,
    output logic [31:0] prom_rdata,
    output logic        prom_cs,
    output logic        prom_sclk,
    output logic        prom_mosi,
    input  logic        prom_miso
);
    import prom_pkg::*;

    logic               blk_wrt;
    logic [QIDX_W-1:0]  wr_index;
    logic [QIDX_W-1:0]  rd_index;
    logic [31:0]        buf_rdata;
    logic [15:0]        debug_word;
    logic               seq_idle;
    logic               clr_index;
    logic               cap_wen;
    logic [31:0]        cap_data;
    logic               shift_start;
    logic [31:0]        tx_word;
    logic [NHALF_W-1:0] n_half;
    logic               rx_mode;
    logic [31:0]        rx_word;
    logic               word_done;
    prom_state_t        state;

    // --------------------------------------------------
    // status word
    // --------------------------------------------------
    assign prom_status[31:STAT_DEBUG_LSB]         = debug_word;
    assign prom_status[STAT_DEBUG_LSB-1:STAT_CS+1] = '0;   // unused
    assign prom_status[STAT_CS]                   = prom_cs;
    assign prom_status[STAT_SCLK]                 = prom_sclk;
    assign prom_status[STAT_MISO]                 = prom_miso;
    assign prom_status[STAT_MOSI]                 = prom_mosi;
    assign prom_status[STAT_BLK_WRT]              = blk_wrt;
    assign prom_status[STAT_STATE_MSB:0]          = state;

    prom_block_buffer buf_inst (
        .clk, .reset, .reg_waddr, .reg_raddr, .reg_wen, .blk_wstart, .blk_wen,
        .prom_cmd, .seq_idle, .clr_index, .cap_wen, .cap_data, .rd_index,
        .blk_wrt, .wr_index, .buf_rdata, .prom_rdata, .debug_word
    );

    prom_spi_shifter shifter_inst (
        .clk, .reset, .shift_start, .tx_word, .n_half, .rx_mode, .prom_miso,
        .prom_sclk, .prom_mosi, .rx_word, .word_done
    );

    prom_sequencer seq_inst (
        .clk, .reset, .reg_waddr, .reg_wen, .prom_cmd, .blk_wrt, .wr_index,
        .buf_rdata, .rx_word, .word_done,
        .prom_cs, .seq_idle, .clr_index, .cap_wen, .cap_data, .rd_index,
        .shift_start, .tx_word, .n_half, .rx_mode, .prom_result, .state
    );

endmodule

//--- eeprom_spi_model.sv
// --------------------------------------------------
// behavioral 25AA-style SPI EEPROM, mode 0
// 256-byte array, status reg with WEL and BP,
// page-wrapping writes committed when cs rises
// --------------------------------------------------
`timescale 1ns/10ps

module eeprom_spi_model (
    input  logic prom_cs,
    input  logic prom_sclk,
    input  logic prom_mosi,
    output logic prom_miso
);
    import prom_pkg::*;

    logic [7:0]  mem [256];
    logic [7:0]  pbuf [64];                // page write latch
    logic [7:0]  status = 8'h00;           // bit 1 WEL, 3:2 BP
    logic [7:0]  op = 8'h00;               // current instruction
    logic [7:0]  in_sr = 8'h00;
    logic [7:0]  out_sr = 8'h00;           // byte going out on miso
    logic [7:0]  new_sr = 8'h00;           // WRSR data, held until cs rises
    logic [15:0] addr = 16'h0000;
    int          nbits = 0;                // bits since cs fell

    initial begin
        prom_miso = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i) ^ 8'ha5;        // fill follows the address
    end

    always @(negedge prom_cs) begin        // new instruction
        nbits  = 0;
        op     = 8'h00;
        out_sr = 8'h00;
    end

    // --------------------------------------------------
    // mosi in on rising sclk, handled per byte
    // --------------------------------------------------
    always @(posedge prom_sclk) begin
        if (prom_cs === 1'b0) begin
            in_sr = {in_sr[6:0], prom_mosi};
            nbits = nbits + 1;
            if (nbits % 8 == 0) begin
                if (nbits == 8) begin
                    op = in_sr;
                    case (op)
                        OP_WREN: status[1] = 1'b1;
                        OP_WRDI: status[1] = 1'b0;
                        OP_RDSR: out_sr = status;
                        default: ;
                    endcase
                end else if (op == OP_WRSR && nbits == 16) begin
                    new_sr = in_sr;
                end else if (op == OP_READ || op == OP_WRITE) begin
                    if (nbits == 16) begin
                        addr[15:8] = in_sr;
                    end else if (nbits == 24) begin
                        addr[7:0] = in_sr;
                        for (int i = 0; i < 64; i++)
                            pbuf[i] = mem[{addr[7:6], 6'(i)}];   // page snapshot
                    end else if (op == OP_WRITE) begin
                        pbuf[addr[5:0]] = in_sr;
                        addr[5:0]       = addr[5:0] + 6'd1;     // wraps inside the page
                    end
                    if (op == OP_READ && nbits >= 24) begin
                        out_sr = mem[addr[7:0]];                 // sequential read
                        addr   = addr + 16'd1;
                    end
                end
            end
        end
    end

    always @(negedge prom_sclk) begin      // miso moves as sclk falls
        if (prom_cs === 1'b0) begin
            prom_miso <= out_sr[7];
            out_sr     = {out_sr[6:0], 1'b0};
        end
    end

    always @(posedge prom_cs) begin        // end of instruction
        if (status[1] && op == OP_WRSR && nbits >= 16) begin
            status[3:2] = new_sr[3:2];     // only BP is writable
            status[1]   = 1'b0;
        end else if (status[1] && op == OP_WRITE && nbits > 24) begin
            for (int i = 0; i < 64; i++)
                mem[{addr[7:6], 6'(i)}] = pbuf[i];
            status[1] = 1'b0;
        end
    end

endmodule

//--- prom_programmer_checker.sv
// --------------------------------------------------
// SPI pin protocol checks for the programmer
// --------------------------------------------------
`timescale 1ns/10ps

module prom_programmer_checker (
    input logic clk,
    input logic reset,
    input logic prom_cs,
    input logic prom_sclk,
    input logic prom_mosi
);
    int assert_fails = 0;                  // failure tally

    sclk_in_frame: assert property (@(posedge clk) disable iff (!reset)
        !$stable(prom_sclk) |-> !prom_cs)
        else begin
            assert_fails = assert_fails + 1;
            $error("sclk toggled while cs was high");
        end

    mosi_hold: assert property (@(posedge clk) disable iff (!reset)
        prom_sclk |-> $stable(prom_mosi))  // data moves only on the falling edge
        else begin
            assert_fails = assert_fails + 1;
            $error("mosi changed while sclk was high");
        end

    cs_after_reset: assert property (@(posedge clk) $rose(reset) |-> prom_cs)
        else begin
            assert_fails = assert_fails + 1;
            $error("cs low right after reset");
        end

endmodule

//--- prom_programmer_tb.sv
// --------------------------------------------------
// testbench for the SPI EEPROM programmer
// table driven host steps against an EEPROM model
// --------------------------------------------------
`timescale 1ns/10ps

module prom_programmer_tb;
    import prom_pkg::*;

    typedef enum int {DO_CMD, DO_PAGE_WRITE, DO_READBACK, DO_BAD_BLOCK} step_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [15:0] reg_waddr;
    logic [15:0] reg_raddr;
    logic        reg_wen;
    logic        blk_wstart;
    logic        blk_wen;
    logic [31:0] prom_cmd;
    logic [31:0] prom_status;
    logic [31:0] prom_result;
    logic [31:0] prom_rdata;
    logic        prom_cs;
    logic        prom_sclk;
    logic        prom_mosi;
    logic        prom_miso;

    step_t       kinds [$];                // stimulus table, one entry per step
    logic [15:0] addrs [$];
    logic [31:0] datas [$];
    logic [31:0] exps [$];                 // expected result or masked status
    logic [31:0] page_data [PAGE_QUADS];
    int          errors = 0;
    int          checks = 0;
    bit          table_ready = 1'b0;

    always #50 clk = ~clk;                 // 100 ns period

    prom_programmer prom_programmer_inst (.*);

    eeprom_spi_model eeprom_inst (.prom_cs, .prom_sclk, .prom_mosi, .prom_miso);

    bind prom_programmer prom_programmer_checker checker_inst (
        .clk, .reset, .prom_cs, .prom_sclk, .prom_mosi
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_step(step_t k, logic [15:0] a, logic [31:0] d, logic [31:0] e);
        kinds.push_back(k);
        addrs.push_back(a);
        datas.push_back(d);
        exps.push_back(e);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------------------------------------
    // host bus tasks
    // --------------------------------------------------
    task automatic send_cmd(input logic [31:0] cmd);
        @(posedge clk);
        reg_waddr <= REG_CMD_ADDR;
        prom_cmd  <= cmd;
        reg_wen   <= 1'b1;
        @(posedge clk);
        reg_wen <= 1'b0;
    endtask

    task automatic wait_done();            // busy, then back to IDLE
        @(negedge clk);
        while (prom_status[2:0] == 3'd0)
            @(negedge clk);
        while (prom_status[2:0] != 3'd0)
            @(negedge clk);
    endtask

    task automatic page_write(input logic [15:0] page);
        @(posedge clk);
        reg_waddr  <= 16'h2000;
        blk_wstart <= 1'b1;
        @(posedge clk);
        blk_wstart <= 1'b0;
        reg_wen    <= 1'b1;
        for (int k = 0; k <= PAGE_QUADS; k++) begin
            reg_waddr <= {4'h2, 8'h00, 4'(k)};   // 17th quadlet reuses nibble 0
            if (k == 0)
                prom_cmd <= {OP_WRITE, page + 16'd63, 8'h00};   // pad byte wraps away
            else
                prom_cmd <= page_data[k-1];
            @(posedge clk);
        end
        reg_wen <= 1'b0;
        blk_wen <= 1'b1;
        @(posedge clk);
        blk_wen <= 1'b0;
    endtask

    task automatic readback_page();
        for (int i = 0; i < PAGE_QUADS; i++) begin
            @(posedge clk);
            reg_raddr <= {4'h2, 8'h00, 4'(i)};
            @(posedge clk);                      // one clock of latency
            @(negedge clk);
            check_value($sformatf("prom_rdata[%0d]", i), prom_rdata, page_data[i]);
        end
    endtask

    task automatic bad_block(input logic [15:0] waddr, input logic [31:0] data);
        @(posedge clk);
        reg_waddr  <= 16'h2000;
        blk_wstart <= 1'b1;
        @(posedge clk);
        blk_wstart <= 1'b0;
        reg_waddr  <= waddr;
        prom_cmd   <= data;
        reg_wen    <= 1'b1;
        @(posedge clk);
        reg_wen <= 1'b0;
        blk_wen <= 1'b1;
        @(posedge clk);
        blk_wen <= 1'b0;
        @(negedge clk);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] seed;
        reset      = 1'b0;
        reg_waddr  = 16'h0;
        reg_raddr  = 16'h0;
        reg_wen    = 1'b0;
        blk_wstart = 1'b0;
        blk_wen    = 1'b0;
        prom_cmd   = 32'h0;
        seed       = 32'h9de6;
        for (int i = 0; i < PAGE_QUADS; i++) begin
            seed         = lcg_next(seed);
            page_data[i] = seed;
        end
        add_step(DO_CMD, 16'h0, {OP_WREN, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h02);        // WEL set
        add_step(DO_CMD, 16'h0, {OP_WRDI, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_WREN, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_WRSR, 8'h0c, 16'h0}, 32'h0);  // BP = 11
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h0c);        // WEL gone at cs high
        add_step(DO_CMD, 16'h0, {OP_WRSR, 8'h00, 16'h0}, 32'h0);  // no WREN first
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h0c);        // unchanged
        add_step(DO_CMD, 16'h0, {OP_WREN, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_WRSR, 8'h00, 16'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h0);
        add_step(DO_CMD, 16'h0, {OP_WREN, 24'h0}, 32'h0);
        add_step(DO_PAGE_WRITE, 16'h0040, 32'h0, 32'd17);          // cmd quadlet + 16
        add_step(DO_CMD, 16'h0, {OP_RDSR, 24'h0}, 32'h0);         // write used up WEL
        add_step(DO_CMD, 16'h0, {OP_READ, 16'h0040, 8'h00}, 32'd16);
        add_step(DO_READBACK, 16'h0, 32'h0, 32'h0);
        add_step(DO_BAD_BLOCK, 16'h2005, 32'hdead_beef, 32'h0500_0000);  // nibble 5, index 0
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value("prom_status", prom_status & 32'hffff_00cf, 32'h0000_0080);
        check_value("prom_result", prom_result, 32'h0);

        for (int i = 0; i < kinds.size(); i++) begin
            case (kinds[i])
                DO_CMD, DO_PAGE_WRITE: begin
                    if (kinds[i] == DO_CMD)
                        send_cmd(datas[i]);
                    else
                        page_write(addrs[i]);
                    wait_done();
                    check_value("prom_result", prom_result, exps[i]);
                end
                DO_READBACK: readback_page();
                default: begin
                    bad_block(addrs[i], datas[i]);
                    check_value("prom_status", prom_status & 32'hffff_000f, exps[i]);
                end
            endcase
        end

        errors = errors + prom_programmer_inst.checker_inst.assert_fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // watchdog, 64 clocks per quadlet
    initial begin
        wait (table_ready);
        repeat (200 * kinds.size() * 64) @(posedge clk);
        $display("timeout, the DUT did not finish the stimulus table in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- list.f
prom_pkg.sv
prom_block_buffer.sv
prom_spi_shifter.sv
prom_sequencer.sv
prom_programmer.sv
eeprom_spi_model.sv
prom_programmer_checker.sv
prom_programmer_tb.sv
